/* design/nf_cpu_pkg.sv */
// nf_cpu package holding RV32I opcodes, datapath control codes and the instruction word layout
package nf_cpu_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_DEPTH = 64;     // words, indexed by address bits 7:2

    // major opcode, instr[6:2]
    localparam logic [4:0] OP_R      = 5'b01100;
    localparam logic [4:0] OP_I      = 5'b00100;
    localparam logic [4:0] OP_LOAD   = 5'b00000;
    localparam logic [4:0] OP_STORE  = 5'b01000;
    localparam logic [4:0] OP_BRANCH = 5'b11000;
    localparam logic [4:0] OP_LUI    = 5'b01101;
    localparam logic [4:0] OP_JAL    = 5'b11011;
    localparam logic [4:0] OP_JALR   = 5'b11001;

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLL = 3'd4;
    localparam logic [2:0] ALU_LUI = 3'd5;

    // immediate format
    localparam logic [2:0] I_NONE = 3'd0;
    localparam logic [2:0] I_SEL  = 3'd1;
    localparam logic [2:0] S_SEL  = 3'd2;
    localparam logic [2:0] B_SEL  = 3'd3;
    localparam logic [2:0] U_SEL  = 3'd4;
    localparam logic [2:0] J_SEL  = 3'd5;

    localparam logic SRCB_RD2 = 1'b0;
    localparam logic SRCB_IMM = 1'b1;

    localparam logic [1:0] B_NONE   = 2'd0;
    localparam logic [1:0] B_EQ_NEQ = 2'd1;   // beq/bne, sense picked by branch_hf
    localparam logic [1:0] B_UB     = 2'd2;   // unconditional jump

    localparam logic RES_ALU = 1'b0;
    localparam logic RES_UB  = 1'b1;          // link value pc + 4

    localparam logic RF_ALUR = 1'b0;
    localparam logic RF_DMEM = 1'b1;

    // one instruction word, read in each of the six base formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage : nf_cpu_pkg

/* design/nf_control_unit.sv */
// control unit turning opcode, funct3 and funct7 bit 5 into datapath control levels
`timescale 1ns/1ps

module nf_control_unit (
    input  logic [4:0] opcode,       // instr[6:2]
    input  logic [2:0] funct3,
    input  logic       funct7_5,     // sub vs add
    output logic [2:0] imm_src,      // immediate format
    output logic       srcb_sel,     // alu operand b source
    output logic       res_sel,      // alu result or link value
    output logic [1:0] branch_type,
    output logic       branch_hf,    // 1 for beq, 0 for bne
    output logic       branch_src,   // jalr target from rs1
    output logic       we_rf,
    output logic       we_dm,
    output logic       rf_src,       // write back from alu or memory
    output logic [2:0] alu_code
);

    import nf_cpu_pkg::*;

    assign branch_hf  = ~funct3[0];
    assign branch_src = (opcode == OP_JALR);

    always_comb begin
        we_rf       = 1'b0;                 // unknown codes do nothing
        we_dm       = 1'b0;
        rf_src      = RF_ALUR;
        alu_code    = ALU_ADD;
        srcb_sel    = SRCB_IMM;
        res_sel     = RES_ALU;
        imm_src     = I_NONE;
        branch_type = B_NONE;
        casez ({opcode, funct3, funct7_5})
            {OP_R, 3'b000, 1'b0}: begin
                we_rf = 1'b1; srcb_sel = SRCB_RD2;
            end
            {OP_R, 3'b000, 1'b1}: begin
                we_rf = 1'b1; srcb_sel = SRCB_RD2; alu_code = ALU_SUB;
            end
            {OP_R, 3'b111, 1'b0}: begin
                we_rf = 1'b1; srcb_sel = SRCB_RD2; alu_code = ALU_AND;
            end
            {OP_R, 3'b110, 1'b0}: begin
                we_rf = 1'b1; srcb_sel = SRCB_RD2; alu_code = ALU_OR;
            end
            {OP_R, 3'b001, 1'b0}: begin
                we_rf = 1'b1; srcb_sel = SRCB_RD2; alu_code = ALU_SLL;
            end
            {OP_I, 3'b000, 1'b?}: begin    // addi
                we_rf = 1'b1; imm_src = I_SEL;
            end
            {OP_I, 3'b110, 1'b?}: begin    // ori
                we_rf = 1'b1; imm_src = I_SEL; alu_code = ALU_OR;
            end
            {OP_I, 3'b001, 1'b0}: begin    // slli
                we_rf = 1'b1; imm_src = I_SEL; alu_code = ALU_SLL;
            end
            {OP_LOAD, 3'b010, 1'b?}: begin // lw
                we_rf = 1'b1; imm_src = I_SEL; rf_src = RF_DMEM;
            end
            {OP_STORE, 3'b010, 1'b?}: begin // sw
                we_dm = 1'b1; imm_src = S_SEL;
            end
            {OP_LUI, 3'b???, 1'b?}: begin
                we_rf = 1'b1; imm_src = U_SEL; alu_code = ALU_LUI;
            end
            {OP_BRANCH, 3'b00?, 1'b?}: begin // beq, bne
                srcb_sel = SRCB_RD2; imm_src = B_SEL; branch_type = B_EQ_NEQ;
            end
            {OP_JAL, 3'b???, 1'b?}: begin
                we_rf = 1'b1; imm_src = J_SEL; res_sel = RES_UB; branch_type = B_UB;
            end
            {OP_JALR, 3'b000, 1'b?}: begin
                we_rf = 1'b1; imm_src = I_SEL; res_sel = RES_UB; branch_type = B_UB;
            end
            default: ;
        endcase
    end

endmodule : nf_control_unit

/* design/nf_reg_file.sv */
// register file with 32 registers, two async read ports and one sync write port
`timescale 1ns/1ps

module nf_reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [4:0]                     ra1,
    input  logic [4:0]                     ra2,
    input  logic [4:0]                     wa,
    input  logic                           we,
    input  logic [nf_cpu_pkg::XLEN-1:0]    wd,
    output logic [nf_cpu_pkg::XLEN-1:0]    rd1,
    output logic [nf_cpu_pkg::XLEN-1:0]    rd2
);

    logic [nf_cpu_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && (wa != 5'd0)) begin   // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule : nf_reg_file

/* design/nf_decode_stage.sv */
// decode stage splitting the instruction, building the immediate and reading registers
`timescale 1ns/1ps

module nf_decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [nf_cpu_pkg::XLEN-1:0]    instr,
    input  logic                           wb_we,
    input  logic [4:0]                     wb_addr,
    input  logic [nf_cpu_pkg::XLEN-1:0]    wb_data,
    output logic [nf_cpu_pkg::XLEN-1:0]    rs1_data,
    output logic [nf_cpu_pkg::XLEN-1:0]    rs2_data,
    output logic [nf_cpu_pkg::XLEN-1:0]    imm,
    output logic [4:0]                     rd_addr,
    output logic [2:0]                     alu_code,
    output logic                           srcb_sel,
    output logic [1:0]                     branch_type,
    output logic                           branch_hf,
    output logic                           branch_src,
    output logic                           res_sel,
    output logic                           rf_src,
    output logic                           we_rf,
    output logic                           we_dm
);

    import nf_cpu_pkg::*;

    instr_u     iw;
    logic [2:0] imm_src;

    assign iw      = instr;
    assign rd_addr = iw.r_fmt.rd;       // same bits in every format with rd

    always_comb begin
        case (imm_src)
            I_SEL:   imm = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
            S_SEL:   imm = {{20{iw.s_fmt.imm_11_5[6]}}, iw.s_fmt.imm_11_5, iw.s_fmt.imm_4_0};
            B_SEL:   imm = {{20{iw.b_fmt.imm_12}}, iw.b_fmt.imm_11, iw.b_fmt.imm_10_5,
                            iw.b_fmt.imm_4_1, 1'b0};
            U_SEL:   imm = {iw.u_fmt.imm_31_12, 12'h000};
            J_SEL:   imm = {{12{iw.j_fmt.imm_20}}, iw.j_fmt.imm_19_12, iw.j_fmt.imm_11,
                            iw.j_fmt.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    nf_control_unit nf_control_unit_inst (
        .opcode      (iw.r_fmt.opcode[6:2]),
        .funct3      (iw.r_fmt.funct3),
        .funct7_5    (iw.r_fmt.funct7[5]),
        .imm_src     (imm_src),
        .srcb_sel    (srcb_sel),
        .res_sel     (res_sel),
        .branch_type (branch_type),
        .branch_hf   (branch_hf),
        .branch_src  (branch_src),
        .we_rf       (we_rf),
        .we_dm       (we_dm),
        .rf_src      (rf_src),
        .alu_code    (alu_code)
    );

    nf_reg_file nf_reg_file_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (iw.r_fmt.rs1),
        .ra2   (iw.r_fmt.rs2),
        .wa    (wb_addr),
        .we    (wb_we),
        .wd    (wb_data),
        .rd1   (rs1_data),
        .rd2   (rs2_data)
    );

endmodule : nf_decode_stage

/* design/nf_alu.sv */
// combinational ALU for add, sub, and, or, shift left and lui pass-through
`timescale 1ns/1ps

module nf_alu (
    input  logic [nf_cpu_pkg::XLEN-1:0]    srca,
    input  logic [nf_cpu_pkg::XLEN-1:0]    srcb,
    input  logic [2:0]                     alu_code,
    output logic [nf_cpu_pkg::XLEN-1:0]    result
);

    import nf_cpu_pkg::*;

    always_comb begin
        case (alu_code)
            ALU_ADD: result = srca + srcb;
            ALU_SUB: result = srca - srcb;
            ALU_AND: result = srca & srcb;
            ALU_OR:  result = srca | srcb;
            ALU_SLL: result = srca << srcb[4:0];   // shamt from low five bits
            ALU_LUI: result = srcb;                // upper immediate already shifted
            default: result = '0;
        endcase
    end

endmodule : nf_alu

/* design/nf_execute_stage.sv */
// execute stage selecting operand b, running the ALU and resolving branches
`timescale 1ns/1ps

module nf_execute_stage (
    input  logic [nf_cpu_pkg::XLEN-1:0]    pc,
    input  logic [nf_cpu_pkg::XLEN-1:0]    rs1_data,
    input  logic [nf_cpu_pkg::XLEN-1:0]    rs2_data,
    input  logic [nf_cpu_pkg::XLEN-1:0]    imm,
    input  logic                           srcb_sel,
    input  logic [2:0]                     alu_code,
    input  logic [1:0]                     branch_type,
    input  logic                           branch_hf,
    input  logic                           branch_src,
    output logic [nf_cpu_pkg::XLEN-1:0]    alu_result,
    output logic [nf_cpu_pkg::XLEN-1:0]    store_data,
    output logic                           branch_taken,
    output logic [nf_cpu_pkg::XLEN-1:0]    branch_target
);

    import nf_cpu_pkg::*;

    logic [XLEN-1:0] srcb;
    logic            equal;

    assign srcb       = (srcb_sel == SRCB_IMM) ? imm : rs2_data;
    assign store_data = rs2_data;
    assign equal      = (rs1_data == rs2_data);

    nf_alu nf_alu_inst (
        .srca     (rs1_data),
        .srcb     (srcb),
        .alu_code (alu_code),
        .result   (alu_result)
    );

    always_comb begin
        case (branch_type)
            B_EQ_NEQ: branch_taken = (equal == branch_hf);
            B_UB:     branch_taken = 1'b1;
            default:  branch_taken = 1'b0;
        endcase
    end

    // jalr takes rs1 + imm from the alu, bit 0 cleared
    assign branch_target = branch_src ? {alu_result[XLEN-1:1], 1'b0} : (pc + imm);

endmodule : nf_execute_stage

/* design/nf_result_stage.sv */
// result stage with data memory, write-back select, pc register and retire outputs
`timescale 1ns/1ps

module nf_result_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [nf_cpu_pkg::XLEN-1:0]    alu_result,
    input  logic [nf_cpu_pkg::XLEN-1:0]    store_data,
    input  logic                           branch_taken,
    input  logic [nf_cpu_pkg::XLEN-1:0]    branch_target,
    input  logic                           res_sel,
    input  logic                           rf_src,
    input  logic                           we_rf,
    input  logic                           we_dm,
    input  logic [4:0]                     rd_addr,
    output logic                           wb_we,
    output logic [4:0]                     wb_addr,
    output logic [nf_cpu_pkg::XLEN-1:0]    wb_data,
    output logic [nf_cpu_pkg::XLEN-1:0]    pc,
    output logic                           retire,
    output logic                           rd_we,
    output logic [4:0]                     rd_out_addr,
    output logic [nf_cpu_pkg::XLEN-1:0]    rd_data,
    output logic                           dmem_we
);

    import nf_cpu_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] dmem [DMEM_DEPTH];
    logic [AW-1:0]   dmem_addr;
    logic [XLEN-1:0] pc_plus4;

    assign dmem_addr = alu_result[AW+1:2];   // word index
    assign pc_plus4  = pc + 32'd4;

    assign wb_we   = instr_valid & we_rf;
    assign wb_addr = rd_addr;
    assign wb_data = (rf_src == RF_DMEM) ? dmem[dmem_addr] :
                     (res_sel == RES_UB) ? pc_plus4 : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (instr_valid && we_dm) begin
            dmem[dmem_addr] <= store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            retire  <= 1'b0;
            rd_we   <= 1'b0;
            dmem_we <= 1'b0;
        end else begin
            retire  <= instr_valid;          // one cycle pulse per instruction
            rd_we   <= instr_valid & we_rf;
            dmem_we <= instr_valid & we_dm;
            if (instr_valid)
                pc <= branch_taken ? branch_target : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            rd_out_addr <= rd_addr;
            rd_data     <= wb_data;
        end
    end

endmodule : nf_result_stage

/* design/nf_cpu.sv */
// top of the single-issue RV32I core, wiring decode, execute and result stages
`timescale 1ns/1ps

module nf_cpu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [nf_cpu_pkg::XLEN-1:0]    instr,
    input  logic                           instr_valid,
    output logic [nf_cpu_pkg::XLEN-1:0]    pc,
    output logic                           retire,
    output logic                           rd_we,
    output logic [4:0]                     rd_addr,
    output logic [nf_cpu_pkg::XLEN-1:0]    rd_data,
    output logic                           dmem_we
);

    import nf_cpu_pkg::*;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [4:0]      dec_rd_addr;
    logic [2:0]      alu_code;
    logic            srcb_sel;
    logic [1:0]      branch_type;
    logic            branch_hf;
    logic            branch_src;
    logic            res_sel;
    logic            rf_src;
    logic            we_rf;
    logic            we_dm;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] store_data;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    logic            wb_we;
    logic [4:0]      wb_addr;
    logic [XLEN-1:0] wb_data;

    nf_decode_stage nf_decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .rd_addr     (dec_rd_addr),
        .alu_code    (alu_code),
        .srcb_sel    (srcb_sel),
        .branch_type (branch_type),
        .branch_hf   (branch_hf),
        .branch_src  (branch_src),
        .res_sel     (res_sel),
        .rf_src      (rf_src),
        .we_rf       (we_rf),
        .we_dm       (we_dm)
    );

    nf_execute_stage nf_execute_stage_inst (
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .srcb_sel      (srcb_sel),
        .alu_code      (alu_code),
        .branch_type   (branch_type),
        .branch_hf     (branch_hf),
        .branch_src    (branch_src),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    nf_result_stage nf_result_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .res_sel       (res_sel),
        .rf_src        (rf_src),
        .we_rf         (we_rf),
        .we_dm         (we_dm),
        .rd_addr       (dec_rd_addr),
        .wb_we         (wb_we),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .pc            (pc),
        .retire        (retire),
        .rd_we         (rd_we),
        .rd_out_addr   (rd_addr),
        .rd_data       (rd_data),
        .dmem_we       (dmem_we)
    );

endmodule : nf_cpu

/* tests/nf_cpu_tb.sv */
// testbench for the nf_cpu core, replaying a golden instruction trace and checking retire outputs
`timescale 1ns/1ps

module nf_cpu_tb;

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 10;     // after the rising edge
    localparam int    RESET_CYCLES = 10;
    localparam string GOLDEN_FILE  = "tests/nf_cpu_golden.txt";

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic [31:0] pc;
    logic        retire;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        dmem_we;

    logic [31:0] exp_instr   [$];
    logic [31:0] exp_pc      [$];
    logic        exp_rd_we   [$];
    logic [4:0]  exp_rd_addr [$];
    logic [31:0] exp_rd_data [$];
    logic        exp_dmem_we [$];

    int cycle_count = 0;
    int cycle_limit = 0;

    nf_cpu nf_cpu_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .retire      (retire),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .dmem_we     (dmem_we)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: trace not finished after %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_instr;
        logic [31:0] f_pc;
        logic [31:0] f_data;
        int          f_we;
        int          f_addr;
        int          f_dm;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the golden file %s", GOLDEN_FILE);
            $display("Checks failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() == 0 || line.getc(0) == "#")    // column header
                continue;
            n = $sscanf(line, "%h %h %d %d %h %d", f_instr, f_pc, f_we, f_addr, f_data, f_dm);
            if (n <= 0)
                continue;
            if (n != 6) begin
                $display("golden file line has %0d fields instead of 6: %s", n, line);
                $display("Checks failed");
                $fatal(1);
            end
            exp_instr.push_back(f_instr);
            exp_pc.push_back(f_pc);
            exp_rd_we.push_back(f_we[0]);
            exp_rd_addr.push_back(f_addr[4:0]);
            exp_rd_data.push_back(f_data);
            exp_dmem_we.push_back(f_dm[0]);
        end
        $fclose(fd);
    endtask

    // random word on instr while valid is low, nothing may move
    task automatic run_idle_cycle(input logic [31:0] hold_pc);
        instr       = $urandom();
        instr_valid = 1'b0;
        @(posedge clk);
        #(DRIVE_DELAY);
        check_value("retire", retire, 1'b0);
        check_value("rd_we", rd_we, 1'b0);
        check_value("dmem_we", dmem_we, 1'b0);
        check_value("pc", pc, hold_pc);
    endtask

    task automatic issue_instruction(input int idx);
        check_value("pc", pc, exp_pc[idx]);
        instr       = exp_instr[idx];
        instr_valid = 1'b1;
        @(posedge clk);
        #(DRIVE_DELAY);
        instr_valid = 1'b0;
        if (retire !== 1'b1) begin
            $display("retire stayed low one cycle after instruction %0d (%h)",
                     idx, exp_instr[idx]);
            $display("Checks failed");
            $fatal(1);
        end
        check_value("rd_we", rd_we, exp_rd_we[idx]);
        check_value("dmem_we", dmem_we, exp_dmem_we[idx]);
        if (exp_rd_we[idx]) begin    // rd fields only meaningful on a write
            check_value("rd_addr", rd_addr, exp_rd_addr[idx]);
            check_value("rd_data", rd_data, exp_rd_data[idx]);
        end
    endtask

    initial begin
        void'($urandom(32'h5d92e838));
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        load_golden();
        cycle_limit = 2 * exp_instr.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        repeat (3) run_idle_cycle(32'h0);    // quiet core straight after reset
        for (int i = 0; i < exp_instr.size(); i++) begin
            issue_instruction(i);
            if (i + 1 < exp_instr.size() && ($urandom() % 2) == 1)
                run_idle_cycle(exp_pc[i + 1]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule : nf_cpu_tb

/* tests/nf_cpu_golden.txt */
# instr pc_before rd_we rd_addr rd_data dmem_we
# instr, pc_before and rd_data in hex; rd_we, rd_addr and dmem_we in decimal
12300093 00000000 1 1  00000123 0
0f006113 00000004 1 2  000000f0 0
00409193 00000008 1 3  00001230 0
abcde237 0000000c 1 4  abcde000 0
002082b3 00000010 1 5  00000213 0
40208333 00000014 1 6  00000033 0
0032f3b3 00000018 1 7  00000210 0
00226433 0000001c 1 8  abcde0f0 0
006094b3 00000020 1 9  09180000 0
00508013 00000024 1 0  00000128 0
00200533 00000028 1 10 000000f0 0
04802023 0000002c 0 0  00000000 1
04002583 00000030 1 11 abcde0f0 0
00208463 00000034 0 0  00000000 0
00209663 00000038 0 0  00000000 0
00858863 00000044 0 0  00000000 0
00859863 00000054 0 0  00000000 0
fe0098e3 00000058 0 0  00000000 0
0200066f 00000048 1 12 0000004c 0
010086e7 00000068 1 13 0000006c 0
00160767 00000132 1 14 00000136 0
00d607b3 0000004c 1 15 000000b8 0
40f70833 00000050 1 16 0000007e 0

/* tb.f */
design/nf_cpu_pkg.sv
design/nf_control_unit.sv
design/nf_reg_file.sv
design/nf_decode_stage.sv
design/nf_alu.sv
design/nf_execute_stage.sv
design/nf_result_stage.sv
design/nf_cpu.sv
tests/nf_cpu_tb.sv

/* Bender.yml */
package:
  name: nf_cpu

sources:
  - files:
      - design/nf_cpu_pkg.sv
      - design/nf_control_unit.sv
      - design/nf_reg_file.sv
      - design/nf_decode_stage.sv
      - design/nf_alu.sv
      - design/nf_execute_stage.sv
      - design/nf_result_stage.sv
      - design/nf_cpu.sv
  - target: test
    files:
      - tests/nf_cpu_tb.sv
